// File: source/rp_pkg.sv
// Shared widths, bus region map, register offsets and address view for the analog path
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // Raw ADC word, 2 reserved LSBs
  localparam int SMP_W     = 14;  // Sample and DAC code
  localparam int SUM_W     = 15;  // Mixer sum before clamp

  typedef logic signed [SMP_W-1:0] sample_t;

  ////////////////////////////////////////////////////////////////////////////
  // System bus map
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W   = 23;
  localparam int DATA_W   = 32;
  localparam int REGION_W = 3;   // 8 regions
  localparam int OFFS_W   = 20;  // Byte offset inside one region

  localparam logic [REGION_W-1:0] HK_REGION = 3'd0;  // Housekeeping

  localparam logic [OFFS_W-1:0] REG_ID   = 20'h00;  // Read only
  localparam logic [OFFS_W-1:0] REG_CFG  = 20'h04;
  localparam logic [OFFS_W-1:0] REG_DC_A = 20'h08;
  localparam logic [OFFS_W-1:0] REG_DC_B = 20'h0C;

  // Configuration bit positions
  localparam int CFG_LOOP_BIT = 0;  // Digital loopback
  localparam int CFG_FDA_BIT  = 1;  // Feed-through channel A
  localparam int CFG_FDB_BIT  = 2;  // Feed-through channel B
  localparam int CFG_W        = 3;

  localparam logic [DATA_W-1:0] ID_VALUE = 32'h5250_0A01;

  // Bus address, flat or split into region and offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [OFFS_W-1:0]   offs;
    } field;
  } sys_addr_u;

  // Negative-slope offset code <-> two's complement, its own inverse
  function automatic logic [SMP_W-1:0] flip_slope(input logic [SMP_W-1:0] code);
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// File: source/sys_bus_if.sv
// Register bus link for one address region between the region decoder and a register block
`timescale 1ns/10ps
`default_nettype none

interface sys_bus_if;

  rp_pkg::sys_addr_u         addr;   // Full address, region and offset view
  logic [rp_pkg::DATA_W-1:0] wdata;  // Write data, valid with wen
  logic                      wen;    // One-cycle write strobe
  logic                      ren;    // One-cycle read strobe
  logic [rp_pkg::DATA_W-1:0] rdata;  // Valid with ack
  logic                      ack;    // One cycle after strobe

  // Decoder side drives the request
  modport decoder (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  ack
  );

  // Register block answers
  modport regs (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output ack
  );

endinterface

`default_nettype wire

// File: source/bus_region_decode.sv
// System bus region decoder that routes strobes to housekeeping and answers unmapped regions
`timescale 1ns/10ps
`default_nettype none

module bus_region_decode (
  input  logic                      adc_clk,
  input  logic                      rst_i,
  // System bus from master
  input  logic [rp_pkg::ADDR_W-1:0] sys_addr_i,
  input  logic [rp_pkg::DATA_W-1:0] sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output logic [rp_pkg::DATA_W-1:0] sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  // Region 0
  sys_bus_if.decoder                hk_bus,
  input  logic                      hk_err_i     // Unknown offset flag aligned with hk ack
);

  rp_pkg::sys_addr_u addr_u;
  logic              hk_sel;
  logic              unmap_ack;  // Own reply for regions 1..7

  ////////////////////////////////////////////////////////////////////////////
  // Region select
  ////////////////////////////////////////////////////////////////////////////

  assign addr_u.flat = sys_addr_i;  // Flat word in, region view below
  assign hk_sel      = (addr_u.field.region == rp_pkg::HK_REGION);

  // Strobes reach region 0 only when it is selected
  assign hk_bus.addr  = addr_u;
  assign hk_bus.wdata = sys_wdata_i;
  assign hk_bus.wen   = sys_wen_i & hk_sel;
  assign hk_bus.ren   = sys_ren_i & hk_sel;

  // Own reply with error one cycle after an unmapped strobe
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      unmap_ack <= 1'b0;
    end
    else
    begin
      unmap_ack <= (sys_wen_i | sys_ren_i) & ~hk_sel;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reply merge
  ////////////////////////////////////////////////////////////////////////////

  assign sys_ack_o   = hk_bus.ack | unmap_ack;
  assign sys_err_o   = unmap_ack | (hk_bus.ack & hk_err_i);   // Either source of error
  assign sys_rdata_o = hk_bus.ack ? hk_bus.rdata : '0;        // Zero for unmapped

endmodule

`default_nettype wire

// File: source/housekeeping_regs.sv
// Housekeeping register block with ID, configuration and per-channel DC levels
`timescale 1ns/10ps
`default_nettype none

module housekeeping_regs (
  input  logic            adc_clk,
  input  logic            rst_i,
  sys_bus_if.regs         bus,
  // Configuration out
  output logic            digital_loop_o,
  output logic            feed_a_o,
  output logic            feed_b_o,
  output rp_pkg::sample_t dc_a_o,
  output rp_pkg::sample_t dc_b_o,
  output logic            offs_err_o      // Aligned with bus.ack
);

  logic [rp_pkg::CFG_W-1:0]  cfg_q;
  rp_pkg::sample_t           dc_a_q;
  rp_pkg::sample_t           dc_b_q;
  logic [rp_pkg::OFFS_W-1:0] offs;
  logic                      offs_ok;
  logic [rp_pkg::DATA_W-1:0] rd_mux;

  assign offs = bus.addr.field.offs;

  // Known offsets in this region
  assign offs_ok = (offs == rp_pkg::REG_ID)   || (offs == rp_pkg::REG_CFG) ||
                   (offs == rp_pkg::REG_DC_A) || (offs == rp_pkg::REG_DC_B);

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cfg_q  <= '0;
      dc_a_q <= '0;
      dc_b_q <= '0;
    end
    else if (bus.wen)
    begin
      case (offs)
        rp_pkg::REG_CFG:  cfg_q  <= bus.wdata[rp_pkg::CFG_W-1:0];
        rp_pkg::REG_DC_A: dc_a_q <= bus.wdata[rp_pkg::SMP_W-1:0];
        rp_pkg::REG_DC_B: dc_b_q <= bus.wdata[rp_pkg::SMP_W-1:0];
        default:          ;  // ID read only, rest flagged below
      endcase
    end
  end

  // Read select, DC levels sign extended
  always_comb
  begin
    case (offs)
      rp_pkg::REG_ID:   rd_mux = rp_pkg::ID_VALUE;
      rp_pkg::REG_CFG:  rd_mux = {{(rp_pkg::DATA_W-rp_pkg::CFG_W){1'b0}}, cfg_q};
      rp_pkg::REG_DC_A: rd_mux = {{(rp_pkg::DATA_W-rp_pkg::SMP_W){dc_a_q[rp_pkg::SMP_W-1]}}, dc_a_q};
      rp_pkg::REG_DC_B: rd_mux = {{(rp_pkg::DATA_W-rp_pkg::SMP_W){dc_b_q[rp_pkg::SMP_W-1]}}, dc_b_q};
      default:          rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus reply, one cycle after strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      bus.ack    <= 1'b0;
      offs_err_o <= 1'b0;
    end
    else
    begin
      bus.ack    <= bus.wen | bus.ren;
      offs_err_o <= (bus.wen | bus.ren) & ~offs_ok;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    bus.rdata <= rd_mux;  // Only looked at with ack
  end

  assign digital_loop_o = cfg_q[rp_pkg::CFG_LOOP_BIT];
  assign feed_a_o       = cfg_q[rp_pkg::CFG_FDA_BIT];
  assign feed_b_o       = cfg_q[rp_pkg::CFG_FDB_BIT];
  assign dc_a_o         = dc_a_q;
  assign dc_b_o         = dc_b_q;

endmodule

`default_nettype wire

// File: source/adc_frontend.sv
// ADC front end, registers raw words, converts to two's complement, optional loopback
`timescale 1ns/10ps
`default_nettype none

module adc_frontend (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  input  logic                         digital_loop_i,
  input  rp_pkg::sample_t              loop_a_i,       // Registered mixer output
  input  rp_pkg::sample_t              loop_b_i,
  output rp_pkg::sample_t              smp_a_o,
  output rp_pkg::sample_t              smp_b_o
);

  logic [rp_pkg::SMP_W-1:0] raw_a_q;
  logic [rp_pkg::SMP_W-1:0] raw_b_q;

  // Input registers, 2 low reserved bits dropped
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_a_q <= rp_pkg::flip_slope('0);  // Raw code of zero
      raw_b_q <= rp_pkg::flip_slope('0);
    end
    else
    begin
      raw_a_q <= adc_dat_a_i[rp_pkg::ADC_RAW_W-1 -: rp_pkg::SMP_W];
      raw_b_q <= adc_dat_b_i[rp_pkg::ADC_RAW_W-1 -: rp_pkg::SMP_W];
    end
  end

  // Negative slope to two's complement, loopback overrides
  assign smp_a_o = digital_loop_i ? loop_a_i : rp_pkg::sample_t'(rp_pkg::flip_slope(raw_a_q));
  assign smp_b_o = digital_loop_i ? loop_b_i : rp_pkg::sample_t'(rp_pkg::flip_slope(raw_b_q));

endmodule

`default_nettype wire

// File: source/dac_mixer.sv
// Per-channel mixer, DC level plus optional sample, saturated to 14 bits and registered
`timescale 1ns/10ps
`default_nettype none

module dac_mixer (
  input  logic            adc_clk,
  input  logic            rst_i,
  input  rp_pkg::sample_t smp_a_i,
  input  rp_pkg::sample_t smp_b_i,
  input  rp_pkg::sample_t dc_a_i,
  input  rp_pkg::sample_t dc_b_i,
  input  logic            feed_a_i,
  input  logic            feed_b_i,
  output rp_pkg::sample_t mix_a_o,   // Also loopback source
  output rp_pkg::sample_t mix_b_o
);

  // 15-bit sum, clamp when the two top bits disagree
  function automatic rp_pkg::sample_t mix_sat(input rp_pkg::sample_t dc,
                                              input rp_pkg::sample_t smp,
                                              input logic            feed);
    logic signed [rp_pkg::SUM_W-1:0] sum;
    sum = rp_pkg::SUM_W'(dc);
    if (feed)
      sum = sum + rp_pkg::SUM_W'(smp);
    if (sum[rp_pkg::SUM_W-1] != sum[rp_pkg::SUM_W-2])
      return {sum[rp_pkg::SUM_W-1], {(rp_pkg::SMP_W-1){~sum[rp_pkg::SUM_W-1]}}};  // Full scale
    return sum[rp_pkg::SMP_W-1:0];
  endfunction

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end
    else
    begin
      mix_a_o <= mix_sat(dc_a_i, smp_a_i, feed_a_i);
      mix_b_o <= mix_sat(dc_b_i, smp_b_i, feed_b_i);
    end
  end

endmodule

`default_nettype wire

// File: source/dac_output.sv
// DAC output stage, two's complement to negative-slope code per channel and DAC reset
`timescale 1ns/10ps
`default_nettype none

module dac_output (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  rp_pkg::sample_t          mix_a_i,
  input  rp_pkg::sample_t          mix_b_i,
  output logic [rp_pkg::SMP_W-1:0] dac_dat_a_o,
  output logic [rp_pkg::SMP_W-1:0] dac_dat_b_o,
  output logic                     dac_rst_o
);

  // Output registers
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= rp_pkg::flip_slope('0);  // Mid scale 0x1FFF
      dac_dat_b_o <= rp_pkg::flip_slope('0);
    end
    else
    begin
      dac_dat_a_o <= rp_pkg::flip_slope(mix_a_i);
      dac_dat_b_o <= rp_pkg::flip_slope(mix_b_i);
    end
  end

  // DAC reset, held one cycle past rst_i
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= rst_i;
  end

endmodule

`default_nettype wire

// File: source/rp_analog_top.sv
// Analog data path top with region decoder, housekeeping registers, ADC front end and DAC
`timescale 1ns/10ps
`default_nettype none

module rp_analog_top (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  // ADC
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  // DAC
  output logic [rp_pkg::SMP_W-1:0]     dac_dat_a_o,
  output logic [rp_pkg::SMP_W-1:0]     dac_dat_b_o,
  output logic                         dac_rst_o,
  // System bus
  input  logic [rp_pkg::ADDR_W-1:0]    sys_addr_i,
  input  logic [rp_pkg::DATA_W-1:0]    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output logic [rp_pkg::DATA_W-1:0]    sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o
);

  // Configuration
  logic            digital_loop;
  logic            feed_a;
  logic            feed_b;
  rp_pkg::sample_t dc_a;
  rp_pkg::sample_t dc_b;
  logic            hk_offs_err;

  // Data path
  rp_pkg::sample_t smp_a;
  rp_pkg::sample_t smp_b;
  rp_pkg::sample_t mix_a;
  rp_pkg::sample_t mix_b;

  sys_bus_if hk_bus ();  // Region 0 link

  ////////////////////////////////////////////////////////////////////////////
  // Register access
  ////////////////////////////////////////////////////////////////////////////

  bus_region_decode u_bus_region_decode (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_bus      (hk_bus),
    .hk_err_i    (hk_offs_err)
  );

  housekeeping_regs u_housekeeping_regs (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (hk_bus),
    .digital_loop_o (digital_loop),
    .feed_a_o       (feed_a),
    .feed_b_o       (feed_b),
    .dc_a_o         (dc_a),
    .dc_b_o         (dc_b),
    .offs_err_o     (hk_offs_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path, 3 cycles ADC to DAC
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (mix_a),        // One-cycle loop through mixer
    .loop_b_i       (mix_b),
    .smp_a_o        (smp_a),
    .smp_b_o        (smp_b)
  );

  dac_mixer u_dac_mixer (
    .adc_clk  (adc_clk),
    .rst_i    (rst_i),
    .smp_a_i  (smp_a),
    .smp_b_i  (smp_b),
    .dc_a_i   (dc_a),
    .dc_b_i   (dc_b),
    .feed_a_i (feed_a),
    .feed_b_i (feed_b),
    .mix_a_o  (mix_a),
    .mix_b_o  (mix_b)
  );

  dac_output u_dac_output (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .mix_a_i     (mix_a),
    .mix_b_i     (mix_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: sim/rp_assertions.sv
// Bus reply timing and reset state checks, bound into the region decoder
`timescale 1ns/10ps
`default_nettype none

module rp_assertions (
  input logic adc_clk,
  input logic rst_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i
);

  // Every strobe answered on the next edge
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
                                     (wen_i || ren_i) |=> ack_i)
    else $error("Bus ack missing one cycle after a strobe");

  // No ack out of nowhere
  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
                                     ack_i |-> $past(wen_i || ren_i))
    else $error("Bus ack without a strobe one cycle earlier");

  quiet_in_reset: assert property (@(posedge adc_clk) rst_i |=> (!ack_i && !err_i))
    else $error("Bus ack or err high during reset");

endmodule

bind bus_region_decode rp_assertions u_rp_assertions (
  .adc_clk (adc_clk),
  .rst_i   (rst_i),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .ack_i   (sys_ack_o),
  .err_i   (sys_err_o)
);

`default_nettype wire

// File: sim/rp_checker.sv
// Scoreboard that models the analog path and the register bus, then compares DUT outputs
`timescale 1ns/10ps
`default_nettype none

module rp_checker (
  input  logic                         adc_clk,
  input  logic                         rst_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  input  logic [rp_pkg::SMP_W-1:0]     dac_dat_a_i,
  input  logic [rp_pkg::SMP_W-1:0]     dac_dat_b_i,
  input  logic                         dac_rst_i,
  input  logic [rp_pkg::ADDR_W-1:0]    sys_addr_i,
  input  logic [rp_pkg::DATA_W-1:0]    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  input  logic [rp_pkg::DATA_W-1:0]    sys_rdata_i,
  input  logic                         sys_ack_i,
  input  logic                         sys_err_i,
  output int                           error_count_o,
  output int                           check_count_o
);

  // Model of the data path registers
  logic [rp_pkg::ADC_RAW_W-1:0] raw_a_m;
  logic [rp_pkg::ADC_RAW_W-1:0] raw_b_m;
  logic [rp_pkg::SMP_W-1:0]     mix_a_m;   // Loopback state
  logic [rp_pkg::SMP_W-1:0]     mix_b_m;
  logic [rp_pkg::SMP_W-1:0]     dac_a_m;
  logic [rp_pkg::SMP_W-1:0]     dac_b_m;
  logic [rp_pkg::SMP_W-1:0]     smp_a;
  logic [rp_pkg::SMP_W-1:0]     smp_b;
  logic                         dac_rst_m;
  // Model of the housekeeping registers and bus reply
  logic [rp_pkg::CFG_W-1:0]     cfg_m;
  logic [rp_pkg::SMP_W-1:0]     dc_a_m;
  logic [rp_pkg::SMP_W-1:0]     dc_b_m;
  logic [rp_pkg::REGION_W-1:0]  region;
  logic [rp_pkg::OFFS_W-1:0]    offs;
  logic                         known;
  logic                         ack_m;
  logic                         err_m;
  logic                         rd_m;      // Read with valid data expected
  logic [rp_pkg::DATA_W-1:0]    rdata_m;
  logic                         armed = 1'b0;
  int                           errors = 0;
  int                           checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  // Top 14 bits, all but the MSB inverted
  function automatic logic [rp_pkg::SMP_W-1:0] raw_to_smp(input logic [rp_pkg::ADC_RAW_W-1:0] raw);
    return raw[rp_pkg::ADC_RAW_W-1 -: rp_pkg::SMP_W] ^ {1'b0, {(rp_pkg::SMP_W-1){1'b1}}};
  endfunction

  function automatic logic [rp_pkg::SMP_W-1:0] smp_to_dac(input logic [rp_pkg::SMP_W-1:0] smp);
    return smp ^ {1'b0, {(rp_pkg::SMP_W-1){1'b1}}};  // Negative-slope offset code
  endfunction

  // Reference mixer, integer sum clamped to the signed 14-bit range
  function automatic logic [rp_pkg::SMP_W-1:0] ref_mix(input logic [rp_pkg::SMP_W-1:0] smp,
                                                       input logic                     feed,
                                                       input logic [rp_pkg::SMP_W-1:0] dc);
    int sum;
    int top;
    top = 1 << (rp_pkg::SMP_W - 1);
    sum = int'($signed(dc));
    if (feed)
      sum = sum + int'($signed(smp));
    if (sum > top - 1)
      sum = top - 1;      // Positive full scale
    else if (sum < -top)
      sum = -top;
    return rp_pkg::SMP_W'(sum);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Cycle model, updated on every rising edge
  //////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    armed     = 1'b1;
    dac_rst_m = rst_i;
    region    = sys_addr_i[rp_pkg::ADDR_W-1 -: rp_pkg::REGION_W];
    offs      = sys_addr_i[rp_pkg::OFFS_W-1:0];
    known     = (region == rp_pkg::HK_REGION) &&
                ((offs == rp_pkg::REG_ID)   || (offs == rp_pkg::REG_CFG) ||
                 (offs == rp_pkg::REG_DC_A) || (offs == rp_pkg::REG_DC_B));
    if (rst_i)
    begin
      raw_a_m = {1'b0, {(rp_pkg::ADC_RAW_W-3){1'b1}}, 2'b00};  // Raw word of a zero sample
      raw_b_m = raw_a_m;
      mix_a_m = '0;
      mix_b_m = '0;
      dac_a_m = smp_to_dac('0);
      dac_b_m = smp_to_dac('0);
      cfg_m   = '0;
      dc_a_m  = '0;
      dc_b_m  = '0;
      ack_m   = 1'b0;
      err_m   = 1'b0;
      rd_m    = 1'b0;
    end
    else
    begin
      // Pipeline, oldest stage first so each reads the previous cycle
      smp_a   = cfg_m[rp_pkg::CFG_LOOP_BIT] ? mix_a_m : raw_to_smp(raw_a_m);
      smp_b   = cfg_m[rp_pkg::CFG_LOOP_BIT] ? mix_b_m : raw_to_smp(raw_b_m);
      dac_a_m = smp_to_dac(mix_a_m);
      dac_b_m = smp_to_dac(mix_b_m);
      mix_a_m = ref_mix(smp_a, cfg_m[rp_pkg::CFG_FDA_BIT], dc_a_m);
      mix_b_m = ref_mix(smp_b, cfg_m[rp_pkg::CFG_FDB_BIT], dc_b_m);
      raw_a_m = adc_dat_a_i;
      raw_b_m = adc_dat_b_i;
      // Bus reply one cycle after the strobe
      ack_m = sys_wen_i | sys_ren_i;
      err_m = ack_m & ~known;
      rd_m  = sys_ren_i & known;
      case (offs)
        rp_pkg::REG_ID:   rdata_m = rp_pkg::ID_VALUE;
        rp_pkg::REG_CFG:  rdata_m = rp_pkg::DATA_W'(cfg_m);
        rp_pkg::REG_DC_A: rdata_m = rp_pkg::DATA_W'($signed(dc_a_m));  // Sign extended
        rp_pkg::REG_DC_B: rdata_m = rp_pkg::DATA_W'($signed(dc_b_m));
        default:          rdata_m = '0;
      endcase
      // Writes count from the next cycle on
      if (sys_wen_i && known)
      begin
        if (offs == rp_pkg::REG_CFG)
          cfg_m = sys_wdata_i[rp_pkg::CFG_W-1:0];
        else if (offs == rp_pkg::REG_DC_A)
          dc_a_m = sys_wdata_i[rp_pkg::SMP_W-1:0];
        else if (offs == rp_pkg::REG_DC_B)
          dc_b_m = sys_wdata_i[rp_pkg::SMP_W-1:0];
      end
    end
  end

  // Compare mid cycle, away from the edge
  always @(negedge adc_clk)
  begin
    if (armed)
    begin
      check_value("dac_dat_a_o", 32'(dac_dat_a_i), 32'(dac_a_m));
      check_value("dac_dat_b_o", 32'(dac_dat_b_i), 32'(dac_b_m));
      check_value("dac_rst_o", 32'(dac_rst_i), 32'(dac_rst_m));
      check_value("sys_ack_o", 32'(sys_ack_i), 32'(ack_m));
      check_value("sys_err_o", 32'(sys_err_i), 32'(err_m));
      if (rd_m)
        check_value("sys_rdata_o", sys_rdata_i, rdata_m);
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_rp_analog_top.sv
// Testbench driving the analog path top through register access and ADC stimulus
`timescale 1ns/10ps
`default_nettype none

module tb_rp_analog_top;

  logic                         adc_clk;
  logic                         rst_i;
  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_a;
  logic [rp_pkg::ADC_RAW_W-1:0] adc_dat_b;
  logic [rp_pkg::SMP_W-1:0]     dac_dat_a;
  logic [rp_pkg::SMP_W-1:0]     dac_dat_b;
  logic                         dac_rst;
  logic [rp_pkg::ADDR_W-1:0]    sys_addr;
  logic [rp_pkg::DATA_W-1:0]    sys_wdata;
  logic                         sys_wen;
  logic                         sys_ren;
  logic [rp_pkg::DATA_W-1:0]    sys_rdata;
  logic                         sys_ack;
  logic                         sys_err;
  int                           error_count;
  int                           check_count;
  int                           timeouts = 0;

  rp_analog_top u_rp_analog_top (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .dac_rst_o   (dac_rst),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err)
  );

  rp_checker u_rp_checker (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .adc_dat_a_i   (adc_dat_a),
    .adc_dat_b_i   (adc_dat_b),
    .dac_dat_a_i   (dac_dat_a),
    .dac_dat_b_i   (dac_dat_b),
    .dac_rst_i     (dac_rst),
    .sys_addr_i    (sys_addr),
    .sys_wdata_i   (sys_wdata),
    .sys_wen_i     (sys_wen),
    .sys_ren_i     (sys_ren),
    .sys_rdata_i   (sys_rdata),
    .sys_ack_i     (sys_ack),
    .sys_err_i     (sys_err),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  function automatic logic [rp_pkg::ADDR_W-1:0] reg_addr(input logic [rp_pkg::REGION_W-1:0] region,
                                                         input logic [rp_pkg::OFFS_W-1:0]   offs);
    return {region, offs};
  endfunction

  // One strobe followed by a bounded wait for ack
  task automatic bus_cycle(input logic wr, input logic [rp_pkg::ADDR_W-1:0] addr,
                           input logic [rp_pkg::DATA_W-1:0] data);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    #2;
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = wr;
    sys_ren   = ~wr;
    @(posedge adc_clk);
    #2;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    while ((sys_ack !== 1'b1) && (waited < 8))
    begin
      @(posedge adc_clk);
      #2;
      waited++;
    end
    if (sys_ack !== 1'b1)
    begin
      timeouts++;
      $display("Bus ack never arrived for address %h", addr);
    end
  endtask

  task automatic write_reg(input logic [rp_pkg::ADDR_W-1:0] addr,
                           input logic [rp_pkg::DATA_W-1:0] data);
    bus_cycle(1'b1, addr, data);
  endtask

  task automatic read_reg(input logic [rp_pkg::ADDR_W-1:0] addr);
    bus_cycle(1'b0, addr, '0);  // Data checked by the scoreboard
  endtask

  task automatic run_random_adc(input int cycles);
    repeat (cycles)
    begin
      @(posedge adc_clk);
      #2;
      adc_dat_a = rp_pkg::ADC_RAW_W'($urandom());
      adc_dat_b = rp_pkg::ADC_RAW_W'($urandom());
    end
  endtask

  // All zeros gives positive full scale and all ones negative
  task automatic run_extreme_adc(input int cycles);
    logic pick;
    repeat (cycles)
    begin
      @(posedge adc_clk);
      #2;
      pick      = 1'($urandom());
      adc_dat_a = pick ? '1 : '0;
      adc_dat_b = pick ? '0 : '1;
    end
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) @(posedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(82));
    rst_i     = 1'b1;
    adc_dat_a = '0;
    adc_dat_b = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    repeat (4) @(posedge adc_clk);
    #2;
    rst_i = 1'b0;

    // Register map readback and error replies
    read_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_ID));
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h0000_0005);
    read_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG));
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), -1234);
    read_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A));
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), 4321);
    read_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B));
    read_reg(reg_addr(rp_pkg::HK_REGION, 20'h10));        // Unknown offset
    write_reg(reg_addr(rp_pkg::HK_REGION, 20'h40), 32'h1);
    for (int r = 1; r < 8; r++)
      read_reg(reg_addr(rp_pkg::REGION_W'(r), rp_pkg::REG_ID));
    write_reg(reg_addr(3'd5, rp_pkg::REG_CFG), 32'h7);    // Must not reach region 0
    read_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG));

    // Feed-through with DC at zero
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), 0);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), 0);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h6);
    run_random_adc(200);

    // DC level only
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h0);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), 1234);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), -3000);
    run_random_adc(100);

    // Saturation both ways
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h6);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), 8000);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), -8000);
    run_extreme_adc(60);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), -8000);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), 8000);
    run_extreme_adc(60);

    // Loopback ramp from zero up to full scale
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h0);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), 0);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), 0);
    idle_cycles(4);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h7);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_A), 1000);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_DC_B), 300);
    idle_cycles(40);
    write_reg(reg_addr(rp_pkg::HK_REGION, rp_pkg::REG_CFG), 32'h0);
    idle_cycles(6);

    $display("Checks %0d, check errors %0d, bus timeouts %0d", check_count, error_count, timeouts);
    if ((error_count == 0) && (timeouts == 0) && (check_count > 0))
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  // Hard stop in case the stimulus stalls
  initial
  begin
    repeat (20000) @(posedge adc_clk);
    $display("Watchdog expired before the stimulus finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/rp_pkg.sv
source/sys_bus_if.sv
source/bus_region_decode.sv
source/housekeeping_regs.sv
source/adc_frontend.sv
source/dac_mixer.sv
source/dac_output.sv
source/rp_analog_top.sv
sim/rp_assertions.sv
sim/rp_checker.sv
sim/tb_rp_analog_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# A failed build or a run that stops on an assertion counts as a failure
verilator --binary --timing --assert --top-module tb_rp_analog_top -f src.f -o tb_sim \
  > sim.log 2>&1 && ./obj_dir/tb_sim >> sim.log 2>&1 || echo "Test failed" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && echo "Simulation FAILED, see sim.log" && exit 1
echo "Simulation PASSED"
exit 0
